// ==== mem_stage_pkg.sv ====
package mem_stage_pkg;

    //////////////////////////////////////////////////
    // widths and lane count
    //////////////////////////////////////////////////

    // issue slots in the stage
    localparam int NUM_LANES = 2;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CP0_SEL_W  = 3;

    typedef logic [WORD_W-1:0]     word_t;
    // shared by the register file and CP0
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // opcodes and exception codes
    //////////////////////////////////////////////////

    // load flavours seen by the memory stage
    typedef enum logic [3:0] {
        OP_OTHER = 4'd0,
        OP_LB    = 4'd1,
        OP_LBU   = 4'd2,
        OP_LH    = 4'd3,
        OP_LHU   = 4'd4,
        OP_LW    = 4'd5,
        OP_LWL   = 4'd6,
        OP_LWR   = 4'd7,
        OP_LL    = 4'd8
    } mem_op_e;

    // values follow the Cause.ExcCode field
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13,
        EXC_ERET = 5'd14
    } exc_code_e;

    // bit positions in the per-lane exception vector from execute
    localparam int EXCV_ADEL = 4;
    localparam int EXCV_ADES = 5;
    localparam int EXCV_SYS  = 8;
    localparam int EXCV_BP   = 9;
    localparam int EXCV_RI   = 10;
    localparam int EXCV_OV   = 12;
    localparam int EXCV_TR   = 13;
    localparam int EXCV_ERET = 14;

    //////////////////////////////////////////////////
    // CP0 registers and fields
    //////////////////////////////////////////////////

    localparam reg_addr_t CP0_STATUS = 5'd12;
    localparam reg_addr_t CP0_CAUSE  = 5'd13;

    localparam logic [CP0_SEL_W-1:0] CP0_SEL_STATUS_CAUSE = 3'd0;

    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;

    // interrupt mask in Status, pending bits in Cause
    localparam int INT_FIELD_HI = 15;
    localparam int INT_FIELD_LO = 8;

    // software-writable pending bits of Cause
    localparam int CAUSE_SW_HI = 9;
    localparam int CAUSE_SW_LO = 8;

endpackage

// ==== cp0_int_bypass.sv ====
`timescale 1ns/1ns

module cp0_int_bypass (
    input  mem_stage_pkg::word_t                    cp0_status_i,
    input  mem_stage_pkg::word_t                    cp0_cause_i,
    input  logic                                    commit_we_i,
    input  logic [mem_stage_pkg::CP0_SEL_W-1:0]     commit_sel_i,
    input  mem_stage_pkg::reg_addr_t                commit_waddr_i,
    input  mem_stage_pkg::word_t                    commit_wdata_i,
    output logic                                    int_pending_o
);
    import mem_stage_pkg::*;

    logic                               status_hit;
    logic                               cause_hit;
    word_t                              status_fwd;
    word_t                              cause_fwd;
    logic [INT_FIELD_HI-INT_FIELD_LO:0] int_req;

    //////////////////////////////////////////////////
    // commit write decode
    //////////////////////////////////////////////////

    assign status_hit = commit_we_i
                     && (commit_sel_i == CP0_SEL_STATUS_CAUSE)
                     && (commit_waddr_i == CP0_STATUS);

    assign cause_hit = commit_we_i
                    && (commit_sel_i == CP0_SEL_STATUS_CAUSE)
                    && (commit_waddr_i == CP0_CAUSE);

    // only the mask field of Status is taken from the commit
    always_comb begin
        status_fwd = cp0_status_i;
        if (status_hit) begin
            status_fwd[INT_FIELD_HI:INT_FIELD_LO] = commit_wdata_i[INT_FIELD_HI:INT_FIELD_LO];
        end
    end

    // hardware pending bits stay live, software ones come from the commit
    always_comb begin
        cause_fwd = cp0_cause_i;
        if (cause_hit) begin
            cause_fwd[CAUSE_SW_HI:CAUSE_SW_LO] = commit_wdata_i[CAUSE_SW_HI:CAUSE_SW_LO];
        end
    end

    //////////////////////////////////////////////////
    // interrupt condition
    //////////////////////////////////////////////////

    assign int_req = cause_fwd[INT_FIELD_HI:INT_FIELD_LO]
                   & status_fwd[INT_FIELD_HI:INT_FIELD_LO];

    // masked request, not at exception level, globally enabled
    assign int_pending_o = (|int_req)
                        && !status_fwd[STATUS_EXL]
                        && status_fwd[STATUS_IE];

endmodule

// ==== load_lane.sv ====
`timescale 1ns/1ns

module load_lane (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  mem_stage_pkg::word_t      mem_data_i,
    input  logic                      mem_data_valid_i,
    input  logic [1:0]                mem_addr_lo_i,
    input  logic                      int_pending_i,
    input  mem_stage_pkg::word_t      inst_addr_i,
    input  mem_stage_pkg::mem_op_e    op_i,
    input  mem_stage_pkg::word_t      rt_data_i,
    input  mem_stage_pkg::word_t      wdata_i,
    input  mem_stage_pkg::reg_addr_t  waddr_i,
    input  logic                      we_i,
    input  mem_stage_pkg::word_t      exc_vec_i,
    output logic                      we_o,
    output mem_stage_pkg::reg_addr_t  waddr_o,
    output mem_stage_pkg::word_t      wdata_o,
    output logic                      exc_flag_o,
    output mem_stage_pkg::exc_code_e  exc_code_o
);
    import mem_stage_pkg::*;

    word_t       mem_data;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       load_data;

    //////////////////////////////////////////////////
    // load alignment
    //////////////////////////////////////////////////

    // no valid strobe means the bus returned nothing
    assign mem_data = mem_data_valid_i ? mem_data_i : '0;

    // little endian, byte 0 in the low bits
    assign sel_byte = mem_data[8*mem_addr_lo_i +: 8];
    assign sel_half = mem_addr_lo_i[1] ? mem_data[31:16] : mem_data[15:0];

    always_comb begin
        load_data = wdata_i;
        case (op_i)
            OP_LB: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            OP_LBU: begin
                load_data = {24'b0, sel_byte};
            end
            OP_LH: begin
                // odd offset is unaligned
                if (mem_addr_lo_i[0]) begin
                    load_data = '0;
                end else begin
                    load_data = {{16{sel_half[15]}}, sel_half};
                end
            end
            OP_LHU: begin
                if (mem_addr_lo_i[0]) begin
                    load_data = '0;
                end else begin
                    load_data = {16'b0, sel_half};
                end
            end
            OP_LW, OP_LL: begin
                load_data = mem_data;
            end
            OP_LWL: begin
                // memory fills from the top, rt keeps the low part
                case (mem_addr_lo_i)
                    2'd0:    load_data = {mem_data[7:0], rt_data_i[23:0]};
                    2'd1:    load_data = {mem_data[15:0], rt_data_i[15:0]};
                    2'd2:    load_data = {mem_data[23:0], rt_data_i[7:0]};
                    default: load_data = mem_data;
                endcase
            end
            OP_LWR: begin
                // memory fills from the bottom, rt keeps the high part
                case (mem_addr_lo_i)
                    2'd0:    load_data = mem_data;
                    2'd1:    load_data = {rt_data_i[31:24], mem_data[31:8]};
                    2'd2:    load_data = {rt_data_i[31:16], mem_data[31:16]};
                    default: load_data = {rt_data_i[31:8], mem_data[31:24]};
                endcase
            end
            default: begin
                load_data = wdata_i;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // write-back register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            we_o    <= 1'b0;
            waddr_o <= '0;
            wdata_o <= '0;
        end else begin
            we_o    <= we_i;
            waddr_o <= waddr_i;
            wdata_o <= load_data;
        end
    end

    //////////////////////////////////////////////////
    // lane exception
    //////////////////////////////////////////////////

    // zero address marks a bubble or a flushed slot
    always_comb begin
        exc_flag_o = 1'b0;
        exc_code_o = EXC_INT;
        if (inst_addr_i != '0) begin
            exc_flag_o = 1'b1;
            if (int_pending_i) begin
                exc_code_o = EXC_INT;
            end else if (exc_vec_i[EXCV_ADEL]) begin
                exc_code_o = EXC_ADEL;
            end else if (exc_vec_i[EXCV_ADES]) begin
                exc_code_o = EXC_ADES;
            end else if (exc_vec_i[EXCV_SYS]) begin
                exc_code_o = EXC_SYS;
            end else if (exc_vec_i[EXCV_BP]) begin
                exc_code_o = EXC_BP;
            end else if (exc_vec_i[EXCV_RI]) begin
                exc_code_o = EXC_RI;
            end else if (exc_vec_i[EXCV_OV]) begin
                exc_code_o = EXC_OV;
            end else if (exc_vec_i[EXCV_TR]) begin
                exc_code_o = EXC_TR;
            end else if (exc_vec_i[EXCV_ERET]) begin
                exc_code_o = EXC_ERET;
            end else begin
                exc_flag_o = 1'b0;
            end
        end
    end

endmodule

// ==== exc_select.sv ====
`timescale 1ns/1ns

module exc_select (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic [mem_stage_pkg::NUM_LANES-1:0]  exc_flag_i,
    input  mem_stage_pkg::exc_code_e             exc_code_i [mem_stage_pkg::NUM_LANES],
    output logic                                 exc_flag_o,
    output mem_stage_pkg::exc_code_e             exc_code_o,
    output logic                                 exc_first_o
);
    import mem_stage_pkg::*;

    logic      sel_flag;
    exc_code_e sel_code;
    logic      sel_first;

    //////////////////////////////////////////////////
    // oldest lane wins
    //////////////////////////////////////////////////

    // walk from the youngest lane down so lane 0 lands last
    always_comb begin
        sel_flag  = 1'b0;
        sel_code  = EXC_INT;
        sel_first = 1'b0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (exc_flag_i[i]) begin
                sel_flag  = 1'b1;
                sel_code  = exc_code_i[i];
                sel_first = (i == 0);
            end
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exc_flag_o  <= 1'b0;
            exc_code_o  <= EXC_INT;
            exc_first_o <= 1'b0;
        end else begin
            exc_flag_o  <= sel_flag;
            exc_code_o  <= sel_code;
            exc_first_o <= sel_first;
        end
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    // shared memory read port
    input  mem_stage_pkg::word_t                 mem_data_i,
    input  logic                                 mem_data_valid_i,
    input  mem_stage_pkg::word_t                 mem_addr_i,
    // live CP0 state and the write committing this cycle
    input  mem_stage_pkg::word_t                 cp0_status_i,
    input  mem_stage_pkg::word_t                 cp0_cause_i,
    input  logic                                 commit_we_i,
    input  logic [mem_stage_pkg::CP0_SEL_W-1:0]  commit_sel_i,
    input  mem_stage_pkg::reg_addr_t             commit_waddr_i,
    input  mem_stage_pkg::word_t                 commit_wdata_i,
    // per-lane inputs from execute
    input  mem_stage_pkg::word_t                 inst_addr_i [mem_stage_pkg::NUM_LANES],
    input  mem_stage_pkg::mem_op_e               op_i        [mem_stage_pkg::NUM_LANES],
    input  mem_stage_pkg::word_t                 rt_data_i   [mem_stage_pkg::NUM_LANES],
    input  mem_stage_pkg::word_t                 wdata_i     [mem_stage_pkg::NUM_LANES],
    input  mem_stage_pkg::reg_addr_t             waddr_i     [mem_stage_pkg::NUM_LANES],
    input  logic [mem_stage_pkg::NUM_LANES-1:0]  we_i,
    input  mem_stage_pkg::word_t                 exc_vec_i   [mem_stage_pkg::NUM_LANES],
    // per-lane register-file write to write-back
    output logic [mem_stage_pkg::NUM_LANES-1:0]  we_o,
    output mem_stage_pkg::reg_addr_t             waddr_o     [mem_stage_pkg::NUM_LANES],
    output mem_stage_pkg::word_t                 wdata_o     [mem_stage_pkg::NUM_LANES],
    // selected exception
    output logic                                 exc_flag_o,
    output mem_stage_pkg::exc_code_e             exc_code_o,
    output logic                                 exc_first_o
);
    import mem_stage_pkg::*;

    logic                 int_pending;
    logic [NUM_LANES-1:0] lane_exc_flag;
    exc_code_e            lane_exc_code [NUM_LANES];

    //////////////////////////////////////////////////
    // CP0 forwarding
    //////////////////////////////////////////////////

    cp0_int_bypass i_cp0_int_bypass (
        .cp0_status_i   (cp0_status_i),
        .cp0_cause_i    (cp0_cause_i),
        .commit_we_i    (commit_we_i),
        .commit_sel_i   (commit_sel_i),
        .commit_waddr_i (commit_waddr_i),
        .commit_wdata_i (commit_wdata_i),
        .int_pending_o  (int_pending)
    );

    //////////////////////////////////////////////////
    // issue lanes
    //////////////////////////////////////////////////

    // every lane sees the same read data and byte offset
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        load_lane i_load_lane (
            .clk_i            (clk_i),
            .arst_n_i         (arst_n_i),
            .mem_data_i       (mem_data_i),
            .mem_data_valid_i (mem_data_valid_i),
            .mem_addr_lo_i    (mem_addr_i[1:0]),
            .int_pending_i    (int_pending),
            .inst_addr_i      (inst_addr_i[l]),
            .op_i             (op_i[l]),
            .rt_data_i        (rt_data_i[l]),
            .wdata_i          (wdata_i[l]),
            .waddr_i          (waddr_i[l]),
            .we_i             (we_i[l]),
            .exc_vec_i        (exc_vec_i[l]),
            .we_o             (we_o[l]),
            .waddr_o          (waddr_o[l]),
            .wdata_o          (wdata_o[l]),
            .exc_flag_o       (lane_exc_flag[l]),
            .exc_code_o       (lane_exc_code[l])
        );
    end

    //////////////////////////////////////////////////
    // exception arbitration
    //////////////////////////////////////////////////

    exc_select i_exc_select (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .exc_flag_i  (lane_exc_flag),
        .exc_code_i  (lane_exc_code),
        .exc_flag_o  (exc_flag_o),
        .exc_code_o  (exc_code_o),
        .exc_first_o (exc_first_o)
    );

endmodule

// ==== tb_mem_model.svh ====
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// xorshift32 with the 13/17/5 shift triple
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// write-back data of one lane, byte 0 at the low end
function automatic word_t model_load(
    input mem_op_e    op,
    input word_t      mem,
    input logic       valid,
    input logic [1:0] off,
    input word_t      rt,
    input word_t      alu
);
    word_t d;
    word_t sh;
    int    b;
    d  = valid ? mem : 32'h0;
    b  = 8 * off;
    sh = d >> b;
    case (op)
        OP_LB:        return {{24{sh[7]}}, sh[7:0]};
        OP_LBU:       return {24'h0, sh[7:0]};
        OP_LH:        return off[0] ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
        OP_LHU:       return off[0] ? 32'h0 : {16'h0, sh[15:0]};
        OP_LW, OP_LL: return d;
        // LWL fills from the top end, LWR from the bottom end
        OP_LWL:       return (d << (24 - b)) | (rt & ~(32'hffff_ffff << (24 - b)));
        OP_LWR:       return sh | (rt & ~(32'hffff_ffff >> b));
        default:      return alu;
    endcase
endfunction

// interrupt level after merging the committing CP0 write
function automatic logic model_int(
    input word_t      status,
    input word_t      cause,
    input logic       we,
    input logic [2:0] sel,
    input reg_addr_t  addr,
    input word_t      data
);
    word_t st;
    word_t ca;
    st = status;
    ca = cause;
    if (we && sel == 3'd0 && addr == 5'd12) st[15:8] = data[15:8];
    if (we && sel == 3'd0 && addr == 5'd13) ca[9:8] = data[9:8];
    return ((st[15:8] & ca[15:8]) != 8'h0) && !st[1] && st[0];
endfunction

// {flag, code} of one lane
function automatic logic [5:0] model_lane_exc(input word_t inst, input logic intr, input word_t vec);
    // highest priority first, each code equals its vector bit
    int prio [8] = '{4, 5, 8, 9, 10, 12, 13, 14};
    if (inst == 32'h0) return 6'h0;
    if (intr) return {1'b1, 5'd0};
    foreach (prio[i]) begin
        if (vec[prio[i]]) return {1'b1, 5'(prio[i])};
    end
    return 6'h0;
endfunction

// {flag, first, code} of the oldest excepting lane
function automatic logic [6:0] model_pick(input logic [5:0] lanes [NUM_LANES]);
    for (int i = 0; i < NUM_LANES; i++) begin
        if (lanes[i][5]) return {1'b1, i == 0, lanes[i][4:0]};
    end
    return 7'h0;
endfunction

`endif

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;
    import mem_stage_pkg::*;

    `include "tb_mem_model.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 200;
    localparam int TOTAL_CYCLES = NUM_TESTS * (TEST_CYCLES + 1) + RESET_CYCLES + 2;
    localparam int TIMEOUT_NS   = 2 * TOTAL_CYCLES * CLK_PERIOD;

    logic                 clk;
    logic                 arst_n;
    word_t                mem_data;
    logic                 mem_valid;
    word_t                mem_addr;
    word_t                cp0_status;
    word_t                cp0_cause;
    logic                 commit_we;
    logic [CP0_SEL_W-1:0] commit_sel;
    reg_addr_t            commit_waddr;
    word_t                commit_wdata;
    word_t                inst_addr [NUM_LANES];
    mem_op_e              op [NUM_LANES];
    word_t                rt_data [NUM_LANES];
    word_t                wdata [NUM_LANES];
    reg_addr_t            waddr [NUM_LANES];
    logic [NUM_LANES-1:0] we;
    word_t                exc_vec [NUM_LANES];
    logic [NUM_LANES-1:0] we_o;
    reg_addr_t            waddr_o [NUM_LANES];
    word_t                wdata_o [NUM_LANES];
    logic                 exc_flag_o;
    exc_code_e            exc_code_o;
    logic                 exc_first_o;

    // expected outputs for the inputs driven last
    logic [NUM_LANES-1:0] pend_we = '0;
    reg_addr_t            pend_waddr [NUM_LANES] = '{default: '0};
    word_t                pend_wdata [NUM_LANES] = '{default: '0};
    logic [6:0]           pend_exc = '0;

    logic [31:0] rng = 32'h0bd1fea3;
    int          checks = 0;
    int          errors = 0;
    string       test_names [NUM_TESTS+1] = '{"reset", "passthrough", "load alignment",
        "invalid memory data", "exception priority", "interrupt forwarding", "lane arbitration"};

    mem_stage i_dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .mem_data_i(mem_data), .mem_data_valid_i(mem_valid), .mem_addr_i(mem_addr),
        .cp0_status_i(cp0_status), .cp0_cause_i(cp0_cause), .commit_we_i(commit_we),
        .commit_sel_i(commit_sel), .commit_waddr_i(commit_waddr), .commit_wdata_i(commit_wdata),
        .inst_addr_i(inst_addr), .op_i(op), .rt_data_i(rt_data), .wdata_i(wdata),
        .waddr_i(waddr), .we_i(we), .exc_vec_i(exc_vec),
        .we_o(we_o), .waddr_o(waddr_o), .wdata_o(wdata_o),
        .exc_flag_o(exc_flag_o), .exc_code_o(exc_code_o), .exc_first_o(exc_first_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    function automatic word_t next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("we_o[%0d]", l), pend_we[l], we_o[l]);
            check_value($sformatf("waddr_o[%0d]", l), pend_waddr[l], waddr_o[l]);
            check_value($sformatf("wdata_o[%0d]", l), pend_wdata[l], wdata_o[l]);
        end
        check_value("exc_flag_o", pend_exc[6], exc_flag_o);
        check_value("exc_first_o", pend_exc[5], exc_first_o);
        check_value("exc_code_o", pend_exc[4:0], exc_code_o);
    endtask

    // model of the inputs that the next edge will capture
    task automatic update_model();
        logic       intr;
        logic [5:0] lane_exc [NUM_LANES];
        intr = model_int(cp0_status, cp0_cause, commit_we, commit_sel, commit_waddr, commit_wdata);
        for (int l = 0; l < NUM_LANES; l++) begin
            pend_we[l]    = we[l];
            pend_waddr[l] = waddr[l];
            pend_wdata[l] = model_load(op[l], mem_data, mem_valid, mem_addr[1:0],
                                       rt_data[l], wdata[l]);
            lane_exc[l]   = model_lane_exc(inst_addr[l], intr, exc_vec[l]);
        end
        pend_exc = model_pick(lane_exc);
    endtask

    task automatic drive_inputs(input int test);
        word_t r;
        r = next_random();
        mem_data     <= next_random();
        mem_valid    <= (test != 3);
        mem_addr     <= next_random();
        cp0_status   <= 32'h0;
        cp0_cause    <= next_random();
        commit_we    <= 1'b0;
        commit_sel   <= 3'd0;
        commit_waddr <= 5'd0;
        commit_wdata <= next_random();
        we           <= r[NUM_LANES-1:0];
        for (int l = 0; l < NUM_LANES; l++) begin
            inst_addr[l] <= 32'h0;
            op[l]        <= OP_OTHER;
            rt_data[l]   <= next_random();
            wdata[l]     <= next_random();
            waddr[l]     <= 5'(next_random());
            exc_vec[l]   <= next_random() & next_random() & next_random();
            if (test == 2 || test == 3) begin
                op[l] <= mem_op_e'(4'(1 + next_random() % 8));
            end else if (test == 4 || test == 6) begin
                inst_addr[l] <= (next_random() % 4 == 0) ? 32'h0 : (next_random() | 32'h1);
            end else if (test == 5) begin
                inst_addr[l] <= next_random() | 32'h1;
            end
            if (test == 6) begin
                exc_vec[l] <= (next_random() % 2 == 0) ? 32'h0 : next_random();
            end
        end
        if (test == 5) begin
            // live mask covers only bits 9..8, live pending only bits 15..10
            cp0_status   <= 32'h0000_0301;
            cp0_cause    <= next_random() & 32'hffff_fcff;
            commit_we    <= (next_random() % 4 != 0);
            commit_sel   <= (next_random() % 4 == 0) ? 3'(1 + next_random() % 7) : 3'd0;
            commit_waddr <= 5'd12 + 5'(next_random() % 3);
        end
    endtask

    task automatic run_test(input int test);
        int start_checks;
        int start_errors;
        start_checks = checks;
        start_errors = errors;
        for (int i = 0; i <= TEST_CYCLES; i++) begin
            @(posedge clk);
            if (i < TEST_CYCLES) drive_inputs(test);
            @(negedge clk);
            check_outputs();
            update_model();
        end
        $display("test %0d %s: %0d checks, %0d errors", test, test_names[test],
                 checks - start_checks, errors - start_errors);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        arst_n       = 1'b0;
        mem_data     = '0;
        mem_valid    = 1'b0;
        mem_addr     = '0;
        cp0_status   = '0;
        cp0_cause    = '0;
        commit_we    = 1'b0;
        commit_sel   = '0;
        commit_waddr = '0;
        commit_wdata = '0;
        we           = '0;
        foreach (inst_addr[l]) begin
            inst_addr[l] = '0;
            op[l]        = OP_OTHER;
            rt_data[l]   = '0;
            wdata[l]     = '0;
            waddr[l]     = '0;
            exc_vec[l]   = '0;
        end

        // outputs stay zero in reset and in the cycle after
        // busy random inputs keep reaching the registers meanwhile
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                arst_n <= 1'b1;
            end
            drive_inputs(6);
            @(negedge clk);
            check_outputs();
        end
        update_model();
        $display("test 0 %s: %0d checks, %0d errors", test_names[0], checks, errors);

        for (int t = 1; t <= NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
mem_stage_pkg.sv
cp0_int_bypass.sv
load_lane.sv
exc_select.sv
mem_stage.sv
tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - mem_stage_pkg.sv
  - cp0_int_bypass.sv
  - load_lane.sv
  - exc_select.sv
  - mem_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_stage.sv
